// File: Makefile
TOP := tb_mouse_display

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log

// File: crosshair_render.sv
`timescale 1ns/10ps

module crosshair_render
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [9:0]                 beam_x,
    input  logic [9:0]                 beam_y,
    input  logic                       hsync,
    input  logic                       vsync,
    input  logic                       blank,
    input  mouse_cursor_pkg::cursor_x_t cursor_x,
    input  mouse_cursor_pkg::cursor_y_t cursor_y,
    output logic [7:0]                 color,
    output logic                       hsync_out,
    output logic                       vsync_out,
    output logic                       blank_out
);

    logic on_cross;

    // a full-screen vertical and horizontal line through the cursor
    assign on_cross = ~blank && ((beam_x == cursor_x) || (beam_y == cursor_y));

    // colour and timing leave in the same cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            color     <= 8'h00;
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
            blank_out <= 1'b1;
        end
        else
        begin
            color     <= on_cross ? 8'hFF : 8'h00;
            hsync_out <= hsync;
            vsync_out <= vsync;
            blank_out <= blank;
        end
    end

endmodule

// File: mouse_cursor_defines.svh
`ifndef MOUSE_CURSOR_DEFINES_SVH
`define MOUSE_CURSOR_DEFINES_SVH

// cursor coordinate widths
`define MC_X_BITS 10
`define MC_Y_BITS 10

// 640x480 raster, horizontal timing in pixels
`define MC_H_ACTIVE 640
`define MC_H_FRONT  16
`define MC_H_SYNC   96
`define MC_H_BACK   48

// vertical timing in lines
`define MC_V_ACTIVE 480
`define MC_V_FRONT  10
`define MC_V_SYNC   2
`define MC_V_BACK   33

// idle cycles in mid-frame before a partial PS/2 frame is dropped
`define MC_PS2_TIMEOUT 2000

// cursor position after reset, middle of the screen
`define MC_X_RESET 320
`define MC_Y_RESET 240

`endif

// File: mouse_cursor_pkg.sv
`include "mouse_cursor_defines.svh"

package mouse_cursor_pkg;

    // absolute cursor coordinates, always inside the active area
    typedef logic [`MC_X_BITS-1:0] cursor_x_t;
    typedef logic [`MC_Y_BITS-1:0] cursor_y_t;

    // button bits in the order of the PS/2 status byte bits 2:0
    typedef struct packed {
        logic middle;
        logic right;
        logic left;
    } mouse_buttons_t;

    // 9-bit two's complement movement, sign taken from the status byte
    typedef logic signed [8:0] delta_t;

endpackage

// File: mouse_display_top.sv
`timescale 1ns/10ps

module mouse_display_top
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            ps2_clk,
    input  logic                            ps2_data,
    output logic [7:0]                      color,
    output logic                            hsync_out,
    output logic                            vsync_out,
    output logic                            blank_out,
    output mouse_cursor_pkg::cursor_x_t      cursor_x,
    output mouse_cursor_pkg::cursor_y_t      cursor_y,
    output mouse_cursor_pkg::mouse_buttons_t buttons,
    output logic                            frame_error
);

    logic       byte_valid;
    logic [7:0] byte_data;
    logic [9:0] beam_x;
    logic [9:0] beam_y;
    logic       hsync;
    logic       vsync;
    logic       blank;

    // mouse side
    ps2_rx u_ps2_rx
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .frame_error (frame_error)
    );

    mouse_packet u_mouse_packet
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .frame_error (frame_error),
        .cursor_x    (cursor_x),
        .cursor_y    (cursor_y),
        .buttons     (buttons)
    );

    // video side
    video_timing u_video_timing
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .beam_x (beam_x),
        .beam_y (beam_y),
        .hsync  (hsync),
        .vsync  (vsync),
        .blank  (blank)
    );

    crosshair_render u_crosshair_render
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .beam_x    (beam_x),
        .beam_y    (beam_y),
        .hsync     (hsync),
        .vsync     (vsync),
        .blank     (blank),
        .cursor_x  (cursor_x),
        .cursor_y  (cursor_y),
        .color     (color),
        .hsync_out (hsync_out),
        .vsync_out (vsync_out),
        .blank_out (blank_out)
    );

endmodule

// File: mouse_packet.sv
`timescale 1ns/10ps
`include "mouse_cursor_defines.svh"

module mouse_packet
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            byte_valid,
    input  logic [7:0]                      byte_data,
    input  logic                            frame_error,
    output mouse_cursor_pkg::cursor_x_t      cursor_x,
    output mouse_cursor_pkg::cursor_y_t      cursor_y,
    output mouse_cursor_pkg::mouse_buttons_t buttons
);

    import mouse_cursor_pkg::*;

    localparam int X_MAX = `MC_H_ACTIVE - 1;
    localparam int Y_MAX = `MC_V_ACTIVE - 1;

    logic [1:0]                 byte_idx;
    logic [7:0]                 status_q;
    logic [7:0]                 dx_q;
    delta_t                     dx;
    delta_t                     dy;
    logic signed [`MC_X_BITS+1:0] x_sum;
    logic signed [`MC_Y_BITS+1:0] y_sum;
    cursor_x_t                  x_next;
    cursor_y_t                  y_next;

    // status byte and x movement, held until the y byte arrives
    always_ff @(posedge clk)
    begin
        if (byte_valid && byte_idx == 2'd0)
        begin
            status_q <= byte_data;
        end
        if (byte_valid && byte_idx == 2'd1)
        begin
            dx_q <= byte_data;
        end
    end

    // overflow on an axis means the count is meaningless
    assign dx = status_q[6] ? '0 : $signed({status_q[4], dx_q});
    assign dy = status_q[7] ? '0 : $signed({status_q[5], byte_data});

    // y is inverted, PS/2 reports up as positive
    assign x_sum = $signed({2'b00, cursor_x}) + dx;
    assign y_sum = $signed({2'b00, cursor_y}) - dy;

    always_comb
    begin
        if (x_sum < 0)
            x_next = '0;
        else if (x_sum > X_MAX)
            x_next = cursor_x_t'(X_MAX);
        else
            x_next = x_sum[`MC_X_BITS-1:0];

        if (y_sum < 0)
            y_next = '0;
        else if (y_sum > Y_MAX)
            y_next = cursor_y_t'(Y_MAX);
        else
            y_next = y_sum[`MC_Y_BITS-1:0];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            byte_idx <= 2'd0;
            cursor_x <= cursor_x_t'(`MC_X_RESET);
            cursor_y <= cursor_y_t'(`MC_Y_RESET);
            buttons  <= '0;
        end
        else if (frame_error)
        begin
            // lost byte, realign on the next status byte
            byte_idx <= 2'd0;
        end
        else if (byte_valid)
        begin
            case (byte_idx)
                2'd0:
                begin
                    // bit 3 is always set in a status byte
                    if (byte_data[3])
                        byte_idx <= 2'd1;
                end
                2'd1:
                begin
                    byte_idx <= 2'd2;
                end
                default:
                begin
                    byte_idx <= 2'd0;
                    cursor_x <= x_next;
                    cursor_y <= y_next;
                    buttons  <= mouse_buttons_t'(status_q[2:0]);
                end
            endcase
        end
    end

    a_x_range: assert property (@(posedge clk) disable iff (!rst_n)
        cursor_x < `MC_H_ACTIVE)
        else $error("mouse_packet: cursor_x out of range");

    a_y_range: assert property (@(posedge clk) disable iff (!rst_n)
        cursor_y < `MC_V_ACTIVE)
        else $error("mouse_packet: cursor_y out of range");

endmodule

// File: ps2_rx.sv
`timescale 1ns/10ps
`include "mouse_cursor_defines.svh"

module ps2_rx
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       frame_error
);

    localparam int TO_W = $clog2(`MC_PS2_TIMEOUT);

    logic [1:0]      clk_sync;
    logic [1:0]      data_sync;
    logic            clk_prev;
    logic            fall;
    logic [3:0]      bit_cnt;
    logic [9:0]      shift_q;
    logic [TO_W-1:0] idle_cnt;
    logic            frame_ok;

    // both lines idle high, so the synchronizers reset to one
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end
        else
        begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    // device clock falling edge, data is stable here
    assign fall = clk_prev & ~clk_sync[1];

    // shift_q holds start in bit 0, data in 8:1 and parity in bit 9 once
    // ten bits are in; the stop bit is the live sample
    assign frame_ok = ~shift_q[0] & (^shift_q[9:1]) & data_sync[1];

    always_ff @(posedge clk)
    begin
        if (fall && bit_cnt != 4'd10)
        begin
            shift_q <= {data_sync[1], shift_q[9:1]};
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall && bit_cnt == 4'd10)
        begin
            byte_data <= shift_q[8:1];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt     <= '0;
            idle_cnt    <= '0;
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end
        else
        begin
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
            if (fall)
            begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10)
                begin
                    bit_cnt     <= '0;
                    byte_valid  <= frame_ok;
                    frame_error <= ~frame_ok;
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
            else if (bit_cnt != 4'd0)
            begin
                // device stopped clocking in mid-frame
                if (idle_cnt == TO_W'(`MC_PS2_TIMEOUT - 1))
                begin
                    bit_cnt     <= '0;
                    idle_cnt    <= '0;
                    frame_error <= 1'b1;
                end
                else
                begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(byte_valid && frame_error))
        else $error("ps2_rx: byte_valid and frame_error together");

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        byte_valid |=> !byte_valid)
        else $error("ps2_rx: byte_valid longer than one cycle");

    a_error_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        frame_error |=> !frame_error)
        else $error("ps2_rx: frame_error longer than one cycle");

endmodule

// File: sources.f
+incdir+.
mouse_cursor_pkg.sv
ps2_rx.sv
mouse_packet.sv
video_timing.sv
crosshair_render.sv
mouse_display_top.sv
tb_mouse_display.sv

// File: tb_mouse_display.sv
`timescale 1ns/10ps
`include "mouse_cursor_defines.svh"

module tb_mouse_display;

    import mouse_cursor_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int PS2_HALF      = 20;
    localparam int BYTE_CYCLES   = 11 * 2 * PS2_HALF + 2 * PS2_HALF;
    localparam int CHECK_DELAY   = 300;
    localparam int PACKET_CYCLES = 3 * BYTE_CYCLES + CHECK_DELAY;
    localparam int N_PACKETS     = 60;
    localparam int FRAME_CYCLES  = (`MC_H_ACTIVE + `MC_H_FRONT + `MC_H_SYNC + `MC_H_BACK)
                                 * (`MC_V_ACTIVE + `MC_V_FRONT + `MC_V_SYNC + `MC_V_BACK);
    localparam int WATCHDOG_CYCLES = 5 + N_PACKETS * PACKET_CYCLES + 2 * FRAME_CYCLES;

    logic           clk;
    logic           rst_n;
    logic           ps2_clk;
    logic           ps2_data;
    logic [7:0]     color;
    logic           hsync_out;
    logic           vsync_out;
    logic           blank_out;
    cursor_x_t      cursor_x;
    cursor_y_t      cursor_y;
    mouse_buttons_t buttons;
    logic           frame_error;

    integer seed;
    int     err_count = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     fe_count = 0;
    int     exp_x;
    int     exp_y;
    int     exp_btn;
    event   packet_done;
    event   check_done;

    mouse_display_top dut
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .color       (color),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .blank_out   (blank_out),
        .cursor_x    (cursor_x),
        .cursor_y    (cursor_y),
        .buttons     (buttons),
        .frame_error (frame_error)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected)
        begin
            $display("ERR at %0d ns: %s got %0d expected %0d", $time, name, got, expected);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: FAILED with %0d mismatches", name, err_count - errs_before);
        end
    endtask

    // model cursor: overflow zeroes an axis, y counts upward, clamp to the screen
    function automatic void predict_packet(input logic [7:0] st, input logic [7:0] bx,
                                           input logic [7:0] by);
        delta_t dx;
        delta_t dy;
        int     nx;
        int     ny;
        dx = st[6] ? delta_t'(0) : delta_t'({st[4], bx});
        dy = st[7] ? delta_t'(0) : delta_t'({st[5], by});
        nx = exp_x + int'(dx);
        ny = exp_y - int'(dy);
        if (nx < 0)
            nx = 0;
        if (nx > `MC_H_ACTIVE - 1)
            nx = `MC_H_ACTIVE - 1;
        if (ny < 0)
            ny = 0;
        if (ny > `MC_V_ACTIVE - 1)
            ny = `MC_V_ACTIVE - 1;
        exp_x   = nx;
        exp_y   = ny;
        exp_btn = int'(st[2:0]);
    endfunction

    // device frame: start, data LSB first, odd parity, stop
    task automatic send_byte(input logic [7:0] value, input bit bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~(^value) ^ bad_parity, value, 1'b0};
        for (int i = 0; i < 11; i++)
        begin
            // data changes in the high half of the device clock
            ps2_data = frame[i];
            repeat (PS2_HALF / 2) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(negedge clk);
            ps2_clk = 1'b1;
            repeat (PS2_HALF / 2) @(negedge clk);
        end
        ps2_data = 1'b1;
        repeat (2 * PS2_HALF) @(negedge clk);
    endtask

    // bad_idx picks the byte with broken parity, -1 for none
    task automatic send_packet(input logic [7:0] st, input logic [7:0] bx,
                               input logic [7:0] by, input int bad_idx);
        send_byte(st, bad_idx == 0);
        send_byte(bx, bad_idx == 1);
        send_byte(by, bad_idx == 2);
        -> packet_done;
        @(check_done);
    endtask

    task automatic valid_packet(input logic [7:0] st, input logic [7:0] bx,
                                input logic [7:0] by);
        predict_packet(st, bx, by);
        send_packet(st, bx, by, -1);
    endtask

    // one full frame measured from the start of vsync_out
    task automatic scan_frame();
        logic prev_vs;
        logic prev_hs;
        logic prev_blank;
        logic done;
        int   lines;
        int   col;
        int   lit;
        int   lit_col;
        int   hs_low;
        int   hs_pulses;
        lines     = 0;
        col       = 0;
        lit       = 0;
        lit_col   = -1;
        hs_low    = 0;
        hs_pulses = 0;
        prev_vs   = 1'b0;
        while (!(prev_vs && !vsync_out))
        begin
            prev_vs = vsync_out;
            @(negedge clk);
        end
        prev_vs    = vsync_out;
        prev_hs    = hsync_out;
        prev_blank = blank_out;
        done       = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            // every line carries one hsync pulse of fixed width
            if (!hsync_out)
            begin
                hs_low++;
            end
            else if (!prev_hs)
            begin
                hs_pulses++;
                check_value("hsync_width", hs_low, `MC_H_SYNC);
                hs_low = 0;
            end
            if (!blank_out)
            begin
                if (prev_blank)
                begin
                    lines++;
                    col     = 0;
                    lit     = 0;
                    lit_col = -1;
                end
                if (color == 8'hFF)
                begin
                    lit++;
                    lit_col = col;
                end
                col++;
            end
            else if (!prev_blank)
            begin
                // end of an active line
                check_value("line_width", col, `MC_H_ACTIVE);
                if (lines - 1 == exp_y)
                begin
                    check_value("cursor_row_lit", lit, `MC_H_ACTIVE);
                end
                else
                begin
                    check_value("row_lit", lit, 1);
                    check_value("lit_column", lit_col, exp_x);
                end
            end
            done       = prev_vs && !vsync_out;
            prev_vs    = vsync_out;
            prev_hs    = hsync_out;
            prev_blank = blank_out;
        end
        check_value("active_lines", lines, `MC_V_ACTIVE);
        check_value("hsync_pulses", hs_pulses,
                    `MC_V_ACTIVE + `MC_V_FRONT + `MC_V_SYNC + `MC_V_BACK);
    endtask

    always @(negedge clk)
    begin
        if (rst_n && frame_error)
            fe_count++;
    end

    // compares the DUT cursor with the model once a packet has settled
    initial
    begin
        forever
        begin
            @(packet_done);
            repeat (CHECK_DELAY) @(negedge clk);
            check_value("cursor_x", cursor_x, exp_x);
            check_value("cursor_y", cursor_y, exp_y);
            check_value("buttons", buttons, exp_btn);
            -> check_done;
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        logic [31:0] r;
        logic [7:0]  st;
        int          errs;
        int          fe_before;
        seed     = 32'hf3993924;
        rst_n    = 1'b0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        exp_x    = `MC_X_RESET;
        exp_y    = `MC_Y_RESET;
        exp_btn  = 0;

        // reset values, sampled in the last reset cycle
        repeat (5) @(negedge clk);
        errs = err_count;
        check_value("cursor_x", cursor_x, `MC_X_RESET);
        check_value("cursor_y", cursor_y, `MC_Y_RESET);
        check_value("buttons", buttons, 0);
        check_value("color", color, 0);
        check_value("hsync_out", hsync_out, 1);
        check_value("vsync_out", vsync_out, 1);
        check_value("blank_out", blank_out, 1);
        rst_n = 1'b1;
        repeat (5) @(negedge clk);
        finish_test("reset state", errs);

        errs = err_count;
        for (int n = 0; n < 40; n++)
        begin
            r  = $random(seed);
            st = {2'b00, r[5:4], 1'b1, r[2:0]};
            valid_packet(st, r[15:8], r[23:16]);
        end
        finish_test("random packets", errs);

        errs = err_count;
        for (int n = 0; n < 3; n++)
            valid_packet(8'h08, 8'hFF, 8'h00);
        check_value("cursor_x", cursor_x, `MC_H_ACTIVE - 1);
        for (int n = 0; n < 3; n++)
            valid_packet(8'h18, 8'h00, 8'h00);
        check_value("cursor_x", cursor_x, 0);
        for (int n = 0; n < 2; n++)
            valid_packet(8'h08, 8'h00, 8'hFF);
        check_value("cursor_y", cursor_y, 0);
        for (int n = 0; n < 2; n++)
            valid_packet(8'h28, 8'h00, 8'h00);
        check_value("cursor_y", cursor_y, `MC_V_ACTIVE - 1);
        // x overflow, only y moves
        valid_packet(8'h48, 8'h40, 8'h10);
        check_value("cursor_x", cursor_x, 0);
        check_value("cursor_y", cursor_y, `MC_V_ACTIVE - 1 - 16);
        // y overflow, only x moves
        valid_packet(8'h88, 8'h40, 8'h40);
        check_value("cursor_x", cursor_x, 64);
        check_value("cursor_y", cursor_y, `MC_V_ACTIVE - 1 - 16);
        finish_test("clamp and overflow", errs);

        errs = err_count;
        fe_before = fe_count;
        // broken x byte, the trailing byte has bit 3 clear and is dropped
        send_packet(8'h09, 8'h20, 8'h04, 1);
        check_value("frame_error_pulses", fe_count - fe_before, 1);
        send_byte(8'h00, 1'b0);
        valid_packet(8'h0A, 8'h05, 8'h03);
        finish_test("bad parity and stray byte", errs);

        errs = err_count;
        scan_frame();
        finish_test("crosshair frame", errs);

        $display("summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: video_timing.sv
`timescale 1ns/10ps
`include "mouse_cursor_defines.svh"

module video_timing
(
    input  logic       clk,
    input  logic       rst_n,
    output logic [9:0] beam_x,
    output logic [9:0] beam_y,
    output logic       hsync,
    output logic       vsync,
    output logic       blank
);

    localparam int H_SYNC_START = `MC_H_ACTIVE + `MC_H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + `MC_H_SYNC;
    localparam int H_TOTAL      = H_SYNC_END + `MC_H_BACK;

    localparam int V_SYNC_START = `MC_V_ACTIVE + `MC_V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + `MC_V_SYNC;
    localparam int V_TOTAL      = V_SYNC_END + `MC_V_BACK;

    logic [9:0] h_count;
    logic [9:0] v_count;
    logic       h_last;
    logic       v_last;

    assign h_last = (h_count == 10'(H_TOTAL - 1));
    assign v_last = (v_count == 10'(V_TOTAL - 1));

    // one pixel per clock, line counter steps at the end of each line
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_count <= '0;
            v_count <= '0;
        end
        else
        begin
            if (h_last)
            begin
                h_count <= '0;
                if (v_last)
                    v_count <= '0;
                else
                    v_count <= v_count + 10'd1;
            end
            else
            begin
                h_count <= h_count + 10'd1;
            end
        end
    end

    assign beam_x = h_count;
    assign beam_y = v_count;

    // syncs are active low
    assign hsync = ~((h_count >= 10'(H_SYNC_START)) && (h_count < 10'(H_SYNC_END)));
    assign vsync = ~((v_count >= 10'(V_SYNC_START)) && (v_count < 10'(V_SYNC_END)));
    assign blank = (h_count >= 10'(`MC_H_ACTIVE)) || (v_count >= 10'(`MC_V_ACTIVE));

    a_h_range: assert property (@(posedge clk) disable iff (!rst_n)
        beam_x < H_TOTAL)
        else $error("video_timing: beam_x past horizontal total");

endmodule
